// ==== mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    localparam int LINE_WIDTH = 128;
    localparam int WORD_WIDTH = 32;

    // Memory side command
    typedef enum logic {
        MEM_READ_LINE  = 1'b0,
        MEM_WRITE_WORD = 1'b1
    } mem_op_e;

    // Request from a cache towards memory, held until the response
    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [31:0]           addr;   // Byte address
        logic [WORD_WIDTH-1:0] wdata;
    } mem_req_t;

    // Line is don't-care on a write response
    typedef struct packed {
        logic                  valid;
        logic [LINE_WIDTH-1:0] line;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int ADDR_WIDTH  = 32;
    localparam int OFFSET_BITS = 4;                         // Byte offset in a 16 byte line
    localparam int TAG_BITS    = ADDR_WIDTH - OFFSET_BITS;  // 28

    // CPU port request, stable until done
    typedef struct packed {
        logic                  valid;
        logic                  store;
        logic [ADDR_WIDTH-1:0] addr;
        logic [31:0]           wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        done;
        logic        hit;
        logic [31:0] rdata;  // Only valid on a load
    } cpu_resp_t;

    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_RD_REQ  = 3'd1,
        S_RD_WAIT = 3'd2,
        S_WR_REQ  = 3'd3,
        S_WR_WAIT = 3'd4,
        S_RESPOND = 3'd5
    } cache_state_e;

endpackage

`default_nettype wire

// ==== line_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_store
    import mem_bus_pkg::*, cache_pkg::*;
#(
    parameter int SET_BIT_WIDTH = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [TAG_BITS-1:0]   lookup_tag,
    output logic                  hit,
    output logic [LINE_WIDTH-1:0] hit_line,
    input  logic                  fill,
    input  logic [LINE_WIDTH-1:0] fill_line,
    input  logic                  update,
    input  logic [1:0]            update_word_sel,
    input  logic [WORD_WIDTH-1:0] update_word
);

    localparam int NUM_LINES = 2 ** SET_BIT_WIDTH;

    logic [TAG_BITS-1:0]      tag_q  [NUM_LINES];
    logic [LINE_WIDTH-1:0]    line_q [NUM_LINES];
    logic [NUM_LINES-1:0]     valid_q;
    logic [SET_BIT_WIDTH-1:0] victim_q;   // Next line to replace
    logic [SET_BIT_WIDTH-1:0] hit_idx;

    // Compare against every valid tag in parallel
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (valid_q[i] && (tag_q[i] == lookup_tag)) begin
                hit     = 1'b1;
                hit_idx = SET_BIT_WIDTH'(i);
            end
        end
    end

    assign hit_line = line_q[hit_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (fill) begin
            valid_q[victim_q] <= 1'b1;
            victim_q          <= victim_q + SET_BIT_WIDTH'(1);  // Round robin wrap
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[victim_q]  <= lookup_tag;
            line_q[victim_q] <= fill_line;
        end else if (update && hit) begin
            line_q[hit_idx][update_word_sel*WORD_WIDTH +: WORD_WIDTH] <= update_word;
        end
    end

    // Controller never refills and patches in the same cycle
    a_fill_update_excl: assert property (
        @(posedge clk) disable iff (!arst_n) !(fill && update)
    );

endmodule

`default_nettype wire

// ==== dcache.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache
    import mem_bus_pkg::*, cache_pkg::*;
#(
    parameter int SET_BIT_WIDTH = 2
) (
    input  logic      clk,
    input  logic      arst_n,
    input  cpu_req_t  cpu_req,
    output cpu_resp_t cpu_resp,
    output mem_req_t  mem_req,
    input  mem_resp_t mem_resp
);

    cache_state_e state_q;
    cache_state_e state_d;

    logic [TAG_BITS-1:0]   tag;
    logic [1:0]            word_sel;
    logic                  hit;
    logic [LINE_WIDTH-1:0] hit_line;
    logic                  fill;
    logic                  update;
    logic                  hit_q;
    logic [WORD_WIDTH-1:0] rdata_q;

    assign tag      = cpu_req.addr[ADDR_WIDTH-1:OFFSET_BITS];
    assign word_sel = cpu_req.addr[3:2];  // Word within the line

    assign fill   = (state_q inside {S_RD_REQ, S_RD_WAIT}) && mem_resp.valid;
    assign update = (state_q == S_WR_REQ);  // Store patches a present line at issue

    line_store #(
        .SET_BIT_WIDTH(SET_BIT_WIDTH)
    ) u_line_store (
        .clk            (clk),
        .arst_n         (arst_n),
        .lookup_tag     (tag),
        .hit            (hit),
        .hit_line       (hit_line),
        .fill           (fill),
        .fill_line      (mem_resp.line),
        .update         (update),
        .update_word_sel(word_sel),
        .update_word    (cpu_req.wdata)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (cpu_req.valid) begin
                    if (cpu_req.store) state_d = S_WR_REQ;
                    else if (hit)      state_d = S_RESPOND;
                    else               state_d = S_RD_REQ;
                end
            end
            S_RD_REQ:  state_d = mem_resp.valid ? S_RESPOND : S_RD_WAIT;
            S_RD_WAIT: if (mem_resp.valid) state_d = S_RESPOND;
            S_WR_REQ:  state_d = mem_resp.valid ? S_RESPOND : S_WR_WAIT;
            S_WR_WAIT: if (mem_resp.valid) state_d = S_RESPOND;
            S_RESPOND: state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && cpu_req.valid && !cpu_req.store) begin
            hit_q   <= hit;
            rdata_q <= hit_line[word_sel*WORD_WIDTH +: WORD_WIDTH];
        end
        if (fill) begin
            rdata_q <= mem_resp.line[word_sel*WORD_WIDTH +: WORD_WIDTH];
        end
        if (state_q == S_WR_REQ) begin
            hit_q <= hit;
        end
    end

    assign cpu_resp.done  = (state_q == S_RESPOND);
    assign cpu_resp.hit   = hit_q;
    assign cpu_resp.rdata = rdata_q;

    always_comb begin
        mem_req.valid = state_q inside {S_RD_REQ, S_RD_WAIT, S_WR_REQ, S_WR_WAIT};
        if (state_q inside {S_WR_REQ, S_WR_WAIT}) begin
            mem_req.op   = MEM_WRITE_WORD;
            mem_req.addr = cpu_req.addr;
        end else begin
            mem_req.op   = MEM_READ_LINE;
            mem_req.addr = {tag, {OFFSET_BITS{1'b0}}};  // Line aligned
        end
        mem_req.wdata = cpu_req.wdata;
    end

    // Stays held until answered since the CPU keeps its request steady
    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_req.valid && !mem_resp.valid) |=> $stable(mem_req)
    );

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  mem_req_t  req_0,
    input  mem_req_t  req_1,
    output mem_resp_t resp_0,
    output mem_resp_t resp_1,
    output mem_req_t  mem_req,
    input  mem_resp_t mem_resp
);

    logic lock_q;   // Transaction in flight
    logic owner_q;
    logic last_q;   // Requester served most recently
    logic sel;

    always_comb begin
        if (lock_q)                        sel = owner_q;
        else if (req_0.valid && req_1.valid) sel = ~last_q;
        else                               sel = req_1.valid;
    end

    assign mem_req = sel ? req_1 : req_0;

    // Line goes to both, valid only to the owner
    always_comb begin
        resp_0       = mem_resp;
        resp_1       = mem_resp;
        resp_0.valid = mem_resp.valid && lock_q && !owner_q;
        resp_1.valid = mem_resp.valid && lock_q && owner_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lock_q  <= 1'b0;
            owner_q <= 1'b0;
            last_q  <= 1'b1;  // Port 0 wins the first tie
        end else if (lock_q) begin
            if (mem_resp.valid) lock_q <= 1'b0;
        end else if (mem_req.valid) begin
            lock_q  <= 1'b1;
            owner_q <= sel;
            last_q  <= sel;
        end
    end

    a_resp_one_owner: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_resp.valid |-> $onehot({resp_1.valid, resp_0.valid})
    );

endmodule

`default_nettype wire

// ==== mem_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_timer #(
    parameter int MEM_LATENCY = 4
) (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic busy,
    output logic expired
);

    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    logic [CNT_BITS-1:0] count_q;
    logic                busy_q;

    // Pulses in the last cycle, so a result registered then lands MEM_LATENCY after load
    assign busy    = busy_q;
    assign expired = busy_q && (count_q == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            count_q <= '0;
        end else if (start) begin
            busy_q  <= 1'b1;
            count_q <= CNT_BITS'(MEM_LATENCY - 1);
        end else if (expired) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            count_q <= count_q - CNT_BITS'(1);
        end
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (!arst_n) start |-> !busy
    );

endmodule

`default_nettype wire

// ==== backing_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module backing_memory
    import mem_bus_pkg::*;
#(
    parameter int MEM_LATENCY   = 4,
    parameter int MEM_LINE_BITS = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    input  mem_req_t  mem_req,
    output mem_resp_t mem_resp
);

    localparam int DEPTH       = 2 ** MEM_LINE_BITS;
    localparam int LINE_OFFSET = $clog2(LINE_WIDTH / 8);
    localparam int WSEL_BITS   = $clog2(LINE_WIDTH / WORD_WIDTH);

    logic [LINE_WIDTH-1:0]    mem_q [DEPTH];
    mem_req_t                 req_q;
    logic                     resp_valid_q;
    logic [LINE_WIDTH-1:0]    resp_line_q;
    logic                     accept;
    logic                     busy;
    logic                     expired;
    logic [MEM_LINE_BITS-1:0] line_idx;
    logic [WSEL_BITS-1:0]     word_sel;

    // Requester still holds valid during the response cycle
    assign accept   = mem_req.valid && !busy && !resp_valid_q;
    assign line_idx = req_q.addr[LINE_OFFSET +: MEM_LINE_BITS];  // Upper bits wrap
    assign word_sel = req_q.addr[LINE_OFFSET-1 -: WSEL_BITS];

    mem_timer #(
        .MEM_LATENCY(MEM_LATENCY)
    ) u_mem_timer (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (accept),
        .busy   (busy),
        .expired(expired)
    );

    always_ff @(posedge clk) begin
        if (accept) req_q <= mem_req;
        if (expired) begin
            if (req_q.op == MEM_WRITE_WORD) begin
                mem_q[line_idx][word_sel*WORD_WIDTH +: WORD_WIDTH] <= req_q.wdata;
            end else begin
                resp_line_q <= mem_q[line_idx];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) resp_valid_q <= 1'b0;
        else         resp_valid_q <= expired;  // One cycle pulse
    end

    assign mem_resp.valid = resp_valid_q;
    assign mem_resp.line  = resp_line_q;

endmodule

`default_nettype wire

// ==== dual_dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_dcache_top
    import mem_bus_pkg::*, cache_pkg::*;
#(
    parameter int SET_BIT_WIDTH = 2,
    parameter int MEM_LATENCY   = 4,
    parameter int MEM_LINE_BITS = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    input  cpu_req_t  cpu_req_0,
    input  cpu_req_t  cpu_req_1,
    output cpu_resp_t cpu_resp_0,
    output cpu_resp_t cpu_resp_1
);

    mem_req_t  dc_req_0;
    mem_req_t  dc_req_1;
    mem_resp_t dc_resp_0;
    mem_resp_t dc_resp_1;
    mem_req_t  arb_req;    // Granted request into memory
    mem_resp_t mem_resp;

    dcache #(
        .SET_BIT_WIDTH(SET_BIT_WIDTH)
    ) u_dcache_0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req_0),
        .cpu_resp(cpu_resp_0),
        .mem_req (dc_req_0),
        .mem_resp(dc_resp_0)
    );

    dcache #(
        .SET_BIT_WIDTH(SET_BIT_WIDTH)
    ) u_dcache_1 (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req_1),
        .cpu_resp(cpu_resp_1),
        .mem_req (dc_req_1),
        .mem_resp(dc_resp_1)
    );

    mem_arbiter u_mem_arbiter (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_0   (dc_req_0),
        .req_1   (dc_req_1),
        .resp_0  (dc_resp_0),
        .resp_1  (dc_resp_1),
        .mem_req (arb_req),
        .mem_resp(mem_resp)
    );

    backing_memory #(
        .MEM_LATENCY  (MEM_LATENCY),
        .MEM_LINE_BITS(MEM_LINE_BITS)
    ) u_backing_memory (
        .clk     (clk),
        .arst_n  (arst_n),
        .mem_req (arb_req),
        .mem_resp(mem_resp)
    );

endmodule

`default_nettype wire

// ==== dual_dcache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_dcache_tb
    import cache_pkg::*;
();

    localparam int SET_BIT_WIDTH = 2;
    localparam int MEM_LATENCY   = 4;
    localparam int MEM_LINE_BITS = 8;
    localparam int NUM_WAYS      = 2 ** SET_BIT_WIDTH;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 6;

    // One port's share of a table row
    typedef struct packed {
        logic        act;
        logic        store;
        logic [31:0] addr;
        logic [31:0] data;
        logic        exp_hit;
    } port_op_t;

    typedef port_op_t [1:0] row_t;  // Index 0 is port 0

    logic      clk = 1'b0;
    logic      arst_n;
    cpu_req_t  cpu_req [2];
    cpu_resp_t cpu_resp [2];
    row_t      rows [$];
    int        errors = 0;
    int        checks = 0;

    // Reference model state
    logic [31:0]         mem_model [int unsigned];  // Keyed by word address
    logic [TAG_BITS-1:0] tag_model [2][NUM_WAYS];
    logic                vld_model [2][NUM_WAYS];
    int                  victim_model [2];

    dual_dcache_top #(
        .SET_BIT_WIDTH(SET_BIT_WIDTH),
        .MEM_LATENCY  (MEM_LATENCY),
        .MEM_LINE_BITS(MEM_LINE_BITS)
    ) i_dual_dcache_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req_0 (cpu_req[0]),
        .cpu_req_1 (cpu_req[1]),
        .cpu_resp_0(cpu_resp[0]),
        .cpu_resp_1(cpu_resp[1])
    );

    always #50 clk = ~clk;

    task automatic add_row(input logic act0, input logic st0, input logic [31:0] addr0,
                           input logic hit0, input logic act1, input logic st1,
                           input logic [31:0] addr1, input logic hit1);
        row_t row;
        row[0] = '{act0, st0, addr0, (act0 && st0) ? $urandom() : 32'h0, hit0};
        row[1] = '{act1, st1, addr1, (act1 && st1) ? $urandom() : 32'h0, hit1};
        rows.push_back(row);
    endtask

    // Write-through, no write-allocate, round-robin fill on a load miss
    task automatic model_access(input int p, input port_op_t op, output logic hit,
                                output logic [31:0] rdata);
        int unsigned         key;
        logic [TAG_BITS-1:0] tag;
        key   = op.addr >> 2;
        tag   = op.addr[31:OFFSET_BITS];
        hit   = 1'b0;
        rdata = 'x;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (vld_model[p][w] && (tag_model[p][w] == tag)) hit = 1'b1;
        end
        if (op.store) begin
            mem_model[key] = op.data;
        end else begin
            if (!hit) begin
                tag_model[p][victim_model[p]] = tag;
                vld_model[p][victim_model[p]] = 1'b1;
                victim_model[p] = (victim_model[p] + 1) % NUM_WAYS;
            end
            if (mem_model.exists(key)) begin
                rdata = mem_model[key];
            end else begin
                errors++;
                $display("Table loads address %h before anything was stored there", op.addr);
            end
        end
    endtask

    task automatic check_resp(input int p, input port_op_t op, input logic [31:0] exp_rdata);
        checks++;
        if (cpu_resp[p].hit !== op.exp_hit) begin
            errors++;
            $display("Fail at %0t: cpu_resp_%0d.hit expected %0b got %0b",
                     $time, p, op.exp_hit, cpu_resp[p].hit);
        end
        if (!op.store) begin
            checks++;
            if (cpu_resp[p].rdata !== exp_rdata) begin
                errors++;
                $display("Fail at %0t: cpu_resp_%0d.rdata expected %h got %h",
                         $time, p, exp_rdata, cpu_resp[p].rdata);
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [1:0]  pending;
        logic [31:0] exp_rdata [2];
        logic        model_hit;
        for (int p = 0; p < 2; p++) begin
            exp_rdata[p] = 'x;
            if (rows[r][p].act) begin
                model_access(p, rows[r][p], model_hit, exp_rdata[p]);
                if (model_hit !== rows[r][p].exp_hit) begin
                    errors++;
                    $display("Row %0d port %0d: table expects hit %0b but the model predicts %0b",
                             r, p, rows[r][p].exp_hit, model_hit);
                end
            end
        end
        @(negedge clk);
        for (int p = 0; p < 2; p++) begin
            pending[p] = rows[r][p].act;
            cpu_req[p] = '{rows[r][p].act, rows[r][p].store, rows[r][p].addr, rows[r][p].data};
        end
        while (pending != 2'b00) begin
            @(negedge clk);
            for (int p = 0; p < 2; p++) begin
                if (cpu_resp[p].done === 1'b1) begin
                    if (!pending[p]) begin
                        errors++;
                        $display("Port %0d raised done at %0t with no request pending", p, $time);
                    end else begin
                        pending[p]       = 1'b0;
                        cpu_req[p].valid = 1'b0;  // Release right after done
                        check_resp(p, rows[r][p], exp_rdata[p]);
                    end
                end
            end
        end
    endtask

    initial begin
        void'($urandom(43782));
        arst_n     = 1'b0;
        cpu_req[0] = '0;
        cpu_req[1] = '0;
        for (int p = 0; p < 2; p++) begin
            victim_model[p] = 0;
            for (int w = 0; w < NUM_WAYS; w++) vld_model[p][w] = 1'b0;
        end

        // Port 0 act store addr hit, then port 1 act store addr hit
        add_row(1, 1, 32'h100, 0,  0, 0, 32'h0,   0);  // Store then load, same port
        add_row(1, 1, 32'h108, 0,  0, 0, 32'h0,   0);
        add_row(1, 0, 32'h100, 0,  0, 0, 32'h0,   0);
        add_row(1, 0, 32'h100, 1,  0, 0, 32'h0,   0);
        add_row(1, 0, 32'h108, 1,  0, 0, 32'h0,   0);  // Other word of a cached line
        add_row(1, 1, 32'h108, 1,  0, 0, 32'h0,   0);  // Store hit patches the line
        add_row(1, 0, 32'h108, 1,  0, 0, 32'h0,   0);
        add_row(1, 1, 32'h200, 0,  1, 1, 32'h210, 0);  // Contending stores
        add_row(1, 1, 32'h220, 0,  1, 1, 32'h230, 0);
        add_row(1, 1, 32'h240, 0,  1, 0, 32'h200, 0);
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h210, 0);
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h220, 0);
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h230, 0);
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h240, 0);  // Evicts 0x200
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h200, 0);  // Round robin miss
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h220, 1);
        add_row(1, 0, 32'h210, 0,  1, 0, 32'h108, 0);  // Two line fills at once
        add_row(1, 0, 32'h210, 1,  1, 0, 32'h240, 1);
        add_row(1, 1, 32'h300, 0,  0, 0, 32'h0,   0);  // Shared memory across ports
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h300, 0);
        add_row(0, 0, 32'h0,   0,  1, 0, 32'h300, 1);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Quiet ports after reset
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            for (int p = 0; p < 2; p++) begin
                if (cpu_resp[p].done !== 1'b0) begin
                    errors++;
                    $display("Fail at %0t: cpu_resp_%0d.done expected 0 got %b",
                             $time, p, cpu_resp[p].done);
                end
            end
        end

        for (int r = 0; r < rows.size(); r++) run_row(r);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized once the table is built
    initial begin
        longint timeout_ns;
        #1;
        timeout_ns = (longint'(rows.size()) * 2 * (MEM_LATENCY + 6)
                      + RESET_CYCLES + IDLE_CYCLES + 2) * 100;
        #(timeout_ns);
        $display("Watchdog expired after %0d ns before the table finished", timeout_ns);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dual_dcache_top.f ====
mem_bus_pkg.sv
cache_pkg.sv
line_store.sv
dcache.sv
mem_arbiter.sv
mem_timer.sv
backing_memory.sv
dual_dcache_top.sv
dual_dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dual_dcache_tb
FILELIST  ?= dual_dcache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
